// ==== build.f ====
verilog/sys_defs_pkg.sv
verilog/mult_stage.sv
verilog/mult.sv
verilog/mult_fu.sv
verification/mult_fu_sva.sv
verification/mult_fu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the multiply unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module mult_fu_tb -Mdir obj_dir -f build.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vmult_fu_tb)
status=$?
printf '%s\n' "$output"

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -q "^PASS: all tests$"; then
    exit 0
fi

echo "simulation did not report a pass"
exit 1

// ==== verification/mult_fu_tb.sv ====
// mult_fu_tb: testbench for the pipelined multiply unit
// table, latency, stall, random and reset traffic checked in issue order

`timescale 1ns/10ps
`default_nettype none

module mult_fu_tb;

    logic                              clock;
    logic                              reset;
    logic                              issue_valid;
    logic [sys_defs_pkg::XLEN-1:0]     opa;
    logic [sys_defs_pkg::XLEN-1:0]     opb;
    sys_defs_pkg::mult_func_t          func;
    logic [sys_defs_pkg::TAG_BITS-1:0] dest_tag;
    logic                              issue_ready;
    logic                              result_ready;
    logic                              result_valid;
    logic [sys_defs_pkg::XLEN-1:0]     result;
    logic [sys_defs_pkg::TAG_BITS-1:0] result_tag;

    // operation table with hand-derived results
    logic [sys_defs_pkg::XLEN-1:0]     tbl_a   [$];
    logic [sys_defs_pkg::XLEN-1:0]     tbl_b   [$];
    sys_defs_pkg::mult_func_t          tbl_f   [$];
    logic [sys_defs_pkg::XLEN-1:0]     tbl_exp [$];

    // scoreboard, oldest operation at the front
    logic [sys_defs_pkg::XLEN-1:0]     exp_q   [$];
    logic [sys_defs_pkg::TAG_BITS-1:0] tag_q   [$];

    integer seed = 54;
    int     errors = 0;
    int     checks = 0;
    int     tests = 0;
    int     failed_tests = 0;

    mult_fu dut (
        .clock        (clock),
        .reset        (reset),
        .issue_valid  (issue_valid),
        .opa          (opa),
        .opb          (opb),
        .func         (func),
        .dest_tag     (dest_tag),
        .issue_ready  (issue_ready),
        .result_ready (result_ready),
        .result_valid (result_valid),
        .result       (result),
        .result_tag   (result_tag)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    // full product per function, then the half the function asks for
    function automatic logic [sys_defs_pkg::XLEN-1:0] ref_product(
        input logic [sys_defs_pkg::XLEN-1:0] a,
        input logic [sys_defs_pkg::XLEN-1:0] b,
        input sys_defs_pkg::mult_func_t      f
    );
        logic [2*sys_defs_pkg::XLEN-1:0] full;
        case (f)
            sys_defs_pkg::MUL_ALU_MULHU:
                full = {{sys_defs_pkg::XLEN{1'b0}}, a} * {{sys_defs_pkg::XLEN{1'b0}}, b};
            sys_defs_pkg::MUL_ALU_MULHSU:
                full = $signed({{sys_defs_pkg::XLEN{a[sys_defs_pkg::XLEN-1]}}, a})
                     * $signed({{sys_defs_pkg::XLEN{1'b0}}, b});
            default:
                full = $signed({{sys_defs_pkg::XLEN{a[sys_defs_pkg::XLEN-1]}}, a})
                     * $signed({{sys_defs_pkg::XLEN{b[sys_defs_pkg::XLEN-1]}}, b});
        endcase
        if (f == sys_defs_pkg::MUL_ALU_MUL) begin
            return full[sys_defs_pkg::XLEN-1:0];
        end
        return full[2*sys_defs_pkg::XLEN-1:sys_defs_pkg::XLEN];
    endfunction

    // corner value now and then, otherwise a full random word
    function automatic logic [sys_defs_pkg::XLEN-1:0] rand_operand();
        integer r;
        r = $random(seed);
        case (r[2:0])
            3'd0: return '0;
            3'd1: return {1'b1, {(sys_defs_pkg::XLEN-1){1'b0}}};
            3'd2: return '1;
            default: return {$random(seed), $random(seed)};
        endcase
    endfunction

    task automatic add_op(
        input logic [sys_defs_pkg::XLEN-1:0] a,
        input logic [sys_defs_pkg::XLEN-1:0] b,
        input sys_defs_pkg::mult_func_t      f,
        input logic [sys_defs_pkg::XLEN-1:0] exp
    );
        tbl_a.push_back(a);
        tbl_b.push_back(b);
        tbl_f.push_back(f);
        tbl_exp.push_back(exp);
    endtask

    // next driving point, 10 ns past the rising edge
    task automatic step();
        @(posedge clock);
        #10;
    endtask

    // hold one operation on the issue port until accepted
    task automatic issue_op(
        input logic [sys_defs_pkg::XLEN-1:0]     a,
        input logic [sys_defs_pkg::XLEN-1:0]     b,
        input sys_defs_pkg::mult_func_t          f,
        input logic [sys_defs_pkg::TAG_BITS-1:0] tag,
        input logic [sys_defs_pkg::XLEN-1:0]     exp
    );
        bit taken;
        int n;
        taken = 1'b0;
        n = 0;
        opa = a;
        opb = b;
        func = f;
        dest_tag = tag;
        issue_valid = 1'b1;
        while (!taken && n < 50) begin
            @(negedge clock);
            taken = issue_ready;
            step();
            n++;
        end
        issue_valid = 1'b0;
        if (taken) begin
            exp_q.push_back(exp);
            tag_q.push_back(tag);
        end else begin
            $display("timeout: issue_ready stayed low for 50 cycles at %0t", $time);
            errors++;
        end
    endtask

    // wait until every accepted operation has come back
    task automatic drain(input int limit);
        int n;
        n = 0;
        result_ready = 1'b1;
        while ((exp_q.size() > 0 || result_valid) && n < limit) begin
            step();
            n++;
        end
        if (exp_q.size() > 0 || result_valid) begin
            $display("timeout: results still outstanding after %0d cycles", limit);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests++;
        if (errors == errs_before) begin
            $display("test %s: ok", name);
        end else begin
            failed_tests++;
            $display("test %s: failed", name);
        end
    endtask

    // handshakes judged mid-cycle, the transfer happens on the next edge
    always @(negedge clock) begin
        if (reset) begin
            exp_q.delete();
            tag_q.delete();
        end else if (result_valid && result_ready) begin
            checks++;
            if (exp_q.size() == 0) begin
                $display("unexpected result at %0t with no operation outstanding", $time);
                errors++;
            end else begin
                assert (result == exp_q[0] && result_tag == tag_q[0]) else begin
                    $display("** Error at %0t: got %h tag %0d, expected %h tag %0d",
                             $time, result, result_tag, exp_q[0], tag_q[0]);
                    errors++;
                end
                void'(exp_q.pop_front());
                void'(tag_q.pop_front());
            end
        end
    end

    initial begin
        int i;
        int e0;
        int lat;
        int sent;
        int n;
        integer r;
        bit taken;
        logic [sys_defs_pkg::XLEN-1:0] held;

        reset = 1'b1;
        issue_valid = 1'b0;
        opa = '0;
        opb = '0;
        func = sys_defs_pkg::MUL_ALU_MUL;
        dest_tag = '0;
        result_ready = 1'b1;

        // a and b are multiplicand and multiplier, mulhsu treats only a as signed
        add_op(64'h0, 64'h5, sys_defs_pkg::MUL_ALU_MUL, 64'h0);
        add_op(64'h1, '1, sys_defs_pkg::MUL_ALU_MUL, 64'hFFFF_FFFF_FFFF_FFFF);
        add_op('1, '1, sys_defs_pkg::MUL_ALU_MULH, 64'h0);
        add_op('1, '1, sys_defs_pkg::MUL_ALU_MULHU, 64'hFFFF_FFFF_FFFF_FFFE);
        add_op('1, '1, sys_defs_pkg::MUL_ALU_MULHSU, 64'hFFFF_FFFF_FFFF_FFFF);
        add_op(64'h8000_0000_0000_0000, 64'h8000_0000_0000_0000,
               sys_defs_pkg::MUL_ALU_MULH, 64'h4000_0000_0000_0000);
        add_op(64'h8000_0000_0000_0000, 64'h8000_0000_0000_0000,
               sys_defs_pkg::MUL_ALU_MUL, 64'h0);
        add_op(64'h7FFF_FFFF_FFFF_FFFF, 64'h7FFF_FFFF_FFFF_FFFF,
               sys_defs_pkg::MUL_ALU_MULH, 64'h3FFF_FFFF_FFFF_FFFF);
        add_op(64'h8000_0000_0000_0000, 64'h7FFF_FFFF_FFFF_FFFF,
               sys_defs_pkg::MUL_ALU_MULH, 64'hC000_0000_0000_0000);
        add_op(64'h8000_0000_0000_0000, 64'h7FFF_FFFF_FFFF_FFFF,
               sys_defs_pkg::MUL_ALU_MULHU, 64'h3FFF_FFFF_FFFF_FFFF);
        add_op(64'h8000_0000_0000_0000, '1,
               sys_defs_pkg::MUL_ALU_MULHSU, 64'h8000_0000_0000_0000);
        add_op(64'h1, '1, sys_defs_pkg::MUL_ALU_MULHSU, 64'h0);
        add_op(-64'sd3, 64'd7, sys_defs_pkg::MUL_ALU_MUL, 64'hFFFF_FFFF_FFFF_FFEB);
        add_op(-64'sd3, 64'd7, sys_defs_pkg::MUL_ALU_MULH, 64'hFFFF_FFFF_FFFF_FFFF);
        add_op(-64'sd2, 64'd3, sys_defs_pkg::MUL_ALU_MULHSU, 64'hFFFF_FFFF_FFFF_FFFF);
        add_op(64'd7, -64'sd3, sys_defs_pkg::MUL_ALU_MULHU, 64'h6);
        add_op(64'h1_0000_0000, 64'h1_0000_0000, sys_defs_pkg::MUL_ALU_MULHU, 64'h1);
        add_op(64'h7FFF_FFFF_FFFF_FFFF, 64'd2, sys_defs_pkg::MUL_ALU_MUL,
               64'hFFFF_FFFF_FFFF_FFFE);

        repeat (2) @(posedge clock);
        #10;
        reset = 1'b0;
        e0 = errors;
        assert (!result_valid && issue_ready) else begin
            $display("** Error at %0t: unit not idle after reset", $time);
            errors++;
        end
        report_test("reset_idle", e0);

        // one operation at a time
        e0 = errors;
        for (i = 0; i < tbl_a.size(); i++) begin
            issue_op(tbl_a[i], tbl_b[i], tbl_f[i], i[4:0], tbl_exp[i]);
            drain(20);
        end
        report_test("table_single", e0);

        // count from the driving cycle through the acceptance edge
        e0 = errors;
        issue_op(64'd6, 64'd7, sys_defs_pkg::MUL_ALU_MUL, 5'd3, 64'd42);
        lat = 1;
        while (!result_valid && lat < 20) begin
            step();
            lat++;
        end
        if (!result_valid) begin
            $display("timeout: no result_valid within 20 cycles of issue");
            errors++;
        end else begin
            assert (lat == sys_defs_pkg::MULT_STAGES + 1) else begin
                $display("** Error at %0t: result after %0d cycles, expected 9", $time, lat);
                errors++;
            end
        end
        drain(20);
        report_test("latency", e0);

        // whole table on consecutive cycles, functions mixed in flight
        e0 = errors;
        for (i = 0; i < tbl_a.size(); i++) begin
            issue_op(tbl_a[i], tbl_b[i], tbl_f[i], i[4:0] + 5'd8, tbl_exp[i]);
        end
        drain(60);
        report_test("back_to_back", e0);

        // sink stalls with several operations in the pipe
        e0 = errors;
        result_ready = 1'b0;
        for (i = 0; i < 6; i++) begin
            issue_op(tbl_a[i + 2], tbl_b[i + 2], tbl_f[i + 2], i[4:0], tbl_exp[i + 2]);
        end
        n = 0;
        while (!result_valid && n < 20) begin
            step();
            n++;
        end
        if (!result_valid) begin
            $display("timeout: no result_valid while the sink was stalled");
            errors++;
        end
        held = result;
        for (i = 0; i < 6; i++) begin
            assert (result_valid && result == held && !issue_ready) else begin
                $display("** Error at %0t: output not frozen under back-pressure", $time);
                errors++;
            end
            step();
        end
        drain(40);
        report_test("back_pressure", e0);

        // random operands, functions and sink stalls
        e0 = errors;
        sent = 0;
        n = 0;
        while (sent < 200 && n < 3000) begin
            r = $random(seed);
            result_ready = (r[1:0] != 2'b00);
            if (!issue_valid && r[4:2] != 3'b000) begin
                opa = rand_operand();
                opb = rand_operand();
                func = sys_defs_pkg::mult_func_t'(r[6:5]);
                dest_tag = sent[4:0];
                issue_valid = 1'b1;
            end
            @(negedge clock);
            taken = issue_valid && issue_ready;
            step();
            if (taken) begin
                exp_q.push_back(ref_product(opa, opb, func));
                tag_q.push_back(dest_tag);
                issue_valid = 1'b0;
                sent++;
            end
            n++;
        end
        issue_valid = 1'b0;
        if (sent < 200) begin
            $display("timeout: only %0d of 200 random operations issued", sent);
            errors++;
        end
        drain(60);
        report_test("random", e0);

        // reset with operations in flight, nothing may come out afterwards
        e0 = errors;
        for (i = 0; i < 5; i++) begin
            issue_op(tbl_a[i], tbl_b[i], tbl_f[i], i[4:0], tbl_exp[i]);
        end
        step();
        reset = 1'b1;
        step();
        step();
        reset = 1'b0;
        for (i = 0; i < 14; i++) begin
            assert (!result_valid) else begin
                $display("** Error at %0t: stale result after reset", $time);
                errors++;
            end
            step();
        end
        issue_op(tbl_a[12], tbl_b[12], tbl_f[12], 5'd12, tbl_exp[12]);
        drain(20);
        report_test("reset_mid_traffic", e0);

        $display("%0d tests, %0d failed, %0d results checked, %0d errors",
                 tests, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/mult_fu_sva.sv ====
// mult_fu_sva: handshake and reset checks for the multiply unit
// bound into mult_fu, reports only through failing assertions

`timescale 1ns/10ps
`default_nettype none

module mult_fu_sva (
    input logic                                clock,
    input logic                                reset,
    input logic                                issue_ready,
    input logic                                result_ready,
    input logic                                result_valid,
    input logic [sys_defs_pkg::XLEN-1:0]       result,
    input logic [sys_defs_pkg::TAG_BITS-1:0]   result_tag
);

    // holding register is empty on the edge after reset
    a_reset_clears: assert property (@(posedge clock) reset |=> !result_valid)
        else $error("result_valid high after reset");

    // a stalled result keeps its value, its tag and its valid bit
    a_hold_stable: assert property (@(posedge clock) disable iff (reset)
        (result_valid && !result_ready) |=>
            (result_valid && $stable(result) && $stable(result_tag)))
        else $error("held result changed while the sink stalled");

    // issue side stalls exactly when the output is blocked
    a_ready_match: assert property (@(posedge clock) disable iff (reset)
        issue_ready == !(result_valid && !result_ready))
        else $error("issue_ready does not follow the output stall");

endmodule

bind mult_fu mult_fu_sva u_sva (
    .clock        (clock),
    .reset        (reset),
    .issue_ready  (issue_ready),
    .result_ready (result_ready),
    .result_valid (result_valid),
    .result       (result),
    .result_tag   (result_tag)
);

`default_nettype wire

// ==== verilog/mult_fu.sv ====
// mult_fu: multiply functional unit with valid/ready on both sides
// wraps the pipelined multiplier with an output holding register and
// stalls the whole pipe while a finished result waits to be taken

`timescale 1ns/10ps
`default_nettype none

module mult_fu (
    input  logic                                clock,
    input  logic                                reset,
    // issue side
    input  logic                                issue_valid,
    input  logic [sys_defs_pkg::XLEN-1:0]       opa,
    input  logic [sys_defs_pkg::XLEN-1:0]       opb,
    input  sys_defs_pkg::mult_func_t            func,
    input  logic [sys_defs_pkg::TAG_BITS-1:0]   dest_tag,
    output logic                                issue_ready,
    // result side
    input  logic                                result_ready,
    output logic                                result_valid,
    output logic [sys_defs_pkg::XLEN-1:0]       result,
    output logic [sys_defs_pkg::TAG_BITS-1:0]   result_tag
);

    // pipe moves when the holding register is free or drains this cycle
    logic advance;
    // operation enters slice 0
    logic start;

    // multiplier outputs
    logic                              mult_done;
    logic [sys_defs_pkg::XLEN-1:0]     mult_product;
    logic [sys_defs_pkg::TAG_BITS-1:0] mult_tag;

    assign advance     = !result_valid || result_ready;
    // one accept per cycle as long as the pipe moves
    assign issue_ready = advance;
    assign start       = issue_valid && advance;

    mult u_mult (
        .clock     (clock),
        .reset     (reset),
        .advance   (advance),
        .start     (start),
        .mcand     (opa),
        .mplier    (opb),
        .mult_type (func),
        .tag_in    (dest_tag),
        .product   (mult_product),
        .done      (mult_done),
        .tag_out   (mult_tag)
    );

    // holding register valid bit
    // acceptance edge plus MULT_STAGES slices plus this register
    // gives MULT_STAGES+1 edges from issue to result_valid
    always_ff @(posedge clock) begin
        if (reset) begin
            result_valid <= 1'b0;
        end else if (advance) begin
            // loads the next result or empties after a take
            result_valid <= mult_done;
        end
    end

    // held result and tag, steady while the sink stalls
    always_ff @(posedge clock) begin
        if (advance && mult_done) begin
            result     <= mult_product;
            result_tag <= mult_tag;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/mult.sv ====
// mult: pipelined XLEN x XLEN multiplier built from MULT_STAGES slices
// extends the operands by function, runs them down the slice chain and
// picks the low or high half with the function that travelled along

`timescale 1ns/10ps
`default_nettype none

module mult (
    input  logic                                clock,
    input  logic                                reset,
    input  logic                                advance,
    input  logic                                start,
    input  logic [sys_defs_pkg::XLEN-1:0]       mcand,
    input  logic [sys_defs_pkg::XLEN-1:0]       mplier,
    input  sys_defs_pkg::mult_func_t            mult_type,
    input  logic [sys_defs_pkg::TAG_BITS-1:0]   tag_in,
    output logic [sys_defs_pkg::XLEN-1:0]       product,
    output logic                                done,
    output logic [sys_defs_pkg::TAG_BITS-1:0]   tag_out
);

    // operands widened to 2*XLEN
    logic [2*sys_defs_pkg::XLEN-1:0] ext_mcand;
    logic [2*sys_defs_pkg::XLEN-1:0] ext_mplier;

    // links between slices, entry 0 is the chain input
    logic [2*sys_defs_pkg::XLEN-1:0]   sum_chain    [0:sys_defs_pkg::MULT_STAGES];
    logic [2*sys_defs_pkg::XLEN-1:0]   mplier_chain [0:sys_defs_pkg::MULT_STAGES];
    logic [2*sys_defs_pkg::XLEN-1:0]   mcand_chain  [0:sys_defs_pkg::MULT_STAGES];
    logic [sys_defs_pkg::MULT_STAGES:0] done_chain;
    sys_defs_pkg::mult_func_t          func_chain   [0:sys_defs_pkg::MULT_STAGES];
    logic [sys_defs_pkg::TAG_BITS-1:0] tag_chain    [0:sys_defs_pkg::MULT_STAGES];

    // full 2*XLEN product out of the last slice
    logic [2*sys_defs_pkg::XLEN-1:0] full_product;

    // sign or zero extension per function
    // with both operands extended, the 2*XLEN wrap of the product is exact
    always_comb begin
        case (mult_type)
            sys_defs_pkg::MUL_ALU_MULHSU: begin
                // signed multiplicand, unsigned multiplier
                ext_mcand  = {{sys_defs_pkg::XLEN{mcand[sys_defs_pkg::XLEN-1]}}, mcand};
                ext_mplier = {{sys_defs_pkg::XLEN{1'b0}}, mplier};
            end
            sys_defs_pkg::MUL_ALU_MULHU: begin
                ext_mcand  = {{sys_defs_pkg::XLEN{1'b0}}, mcand};
                ext_mplier = {{sys_defs_pkg::XLEN{1'b0}}, mplier};
            end
            default: begin
                // mul and mulh treat both operands as signed
                ext_mcand  = {{sys_defs_pkg::XLEN{mcand[sys_defs_pkg::XLEN-1]}}, mcand};
                ext_mplier = {{sys_defs_pkg::XLEN{mplier[sys_defs_pkg::XLEN-1]}}, mplier};
            end
        endcase
    end

    // chain input, running sum starts at zero
    assign sum_chain[0]    = '0;
    assign mplier_chain[0] = ext_mplier;
    assign mcand_chain[0]  = ext_mcand;
    assign done_chain[0]   = start;
    assign func_chain[0]   = mult_type;
    assign tag_chain[0]    = tag_in;

    // slice k retires multiplier bits [16k+15:16k]
    for (genvar i = 0; i < sys_defs_pkg::MULT_STAGES; i++) begin : g_stage
        mult_stage mstage (
            .clock       (clock),
            .reset       (reset),
            .advance     (advance),
            .start       (done_chain[i]),
            .prev_sum    (sum_chain[i]),
            .mplier      (mplier_chain[i]),
            .mcand       (mcand_chain[i]),
            .func_in     (func_chain[i]),
            .tag_in      (tag_chain[i]),
            .product_sum (sum_chain[i+1]),
            .next_mplier (mplier_chain[i+1]),
            .next_mcand  (mcand_chain[i+1]),
            .done        (done_chain[i+1]),
            .func_out    (func_chain[i+1]),
            .tag_out     (tag_chain[i+1])
        );
    end

    assign full_product = sum_chain[sys_defs_pkg::MULT_STAGES];

    // half select follows the operation now leaving the pipe,
    // not whatever is being issued this cycle
    always_comb begin
        if (func_chain[sys_defs_pkg::MULT_STAGES] == sys_defs_pkg::MUL_ALU_MUL) begin
            product = full_product[sys_defs_pkg::XLEN-1:0];
        end else begin
            product = full_product[2*sys_defs_pkg::XLEN-1:sys_defs_pkg::XLEN];
        end
    end

    assign done    = done_chain[sys_defs_pkg::MULT_STAGES];
    assign tag_out = tag_chain[sys_defs_pkg::MULT_STAGES];

endmodule

`default_nettype wire

// ==== verilog/mult_stage.sv ====
// mult_stage: one slice of the pipelined multiplier
// adds the partial product of the low multiplier chunk to the running sum
// and hands the shifted operands, function and tag on to the next slice

`timescale 1ns/10ps
`default_nettype none

module mult_stage (
    input  logic                                clock,
    input  logic                                reset,
    input  logic                                advance,
    input  logic                                start,
    input  logic [2*sys_defs_pkg::XLEN-1:0]     prev_sum,
    input  logic [2*sys_defs_pkg::XLEN-1:0]     mplier,
    input  logic [2*sys_defs_pkg::XLEN-1:0]     mcand,
    input  sys_defs_pkg::mult_func_t            func_in,
    input  logic [sys_defs_pkg::TAG_BITS-1:0]   tag_in,
    output logic [2*sys_defs_pkg::XLEN-1:0]     product_sum,
    output logic [2*sys_defs_pkg::XLEN-1:0]     next_mplier,
    output logic [2*sys_defs_pkg::XLEN-1:0]     next_mcand,
    output logic                                done,
    output sys_defs_pkg::mult_func_t            func_out,
    output logic [sys_defs_pkg::TAG_BITS-1:0]   tag_out
);

    // low chunk of the multiplier, zero padded to full width
    logic [2*sys_defs_pkg::XLEN-1:0] mplier_chunk;
    // chunk times the (already shifted) multiplicand
    logic [2*sys_defs_pkg::XLEN-1:0] partial_product;

    // upper bits are zero so the wide multiply reduces to chunk x mcand
    assign mplier_chunk = {
        {(2*sys_defs_pkg::XLEN - sys_defs_pkg::MULT_CHUNK){1'b0}},
        mplier[sys_defs_pkg::MULT_CHUNK-1:0]
    };

    // result wraps at 2*XLEN bits, which is all the product needs
    assign partial_product = mplier_chunk * mcand;

    // valid bit of this slice
    // only control state is cleared on reset
    always_ff @(posedge clock) begin
        if (reset) begin
            done <= 1'b0;
        end else if (advance) begin
            done <= start;
        end
    end

    // payload moves only when the pipe advances
    always_ff @(posedge clock) begin
        if (advance) begin
            // accumulate this chunk's contribution
            product_sum <= prev_sum + partial_product;
            // next slice sees the following chunk in the low bits
            next_mplier <= mplier >> sys_defs_pkg::MULT_CHUNK;
            // and a multiplicand weighted by the chunk position
            next_mcand  <= mcand << sys_defs_pkg::MULT_CHUNK;
            // function and tag stay with their operation
            func_out    <= func_in;
            tag_out     <= tag_in;
        end
    end

    // a frozen pipe keeps every register above unchanged,
    // so an operation never slips past a stalled neighbour

endmodule

`default_nettype wire

// ==== verilog/sys_defs_pkg.sv ====
// shared definitions for the pipelined multiply functional unit
// data width, pipeline depth, tag width and the multiply function encoding

`default_nettype none

package sys_defs_pkg;

    // operand and result width
    localparam int unsigned XLEN = 64;

    // number of pipeline slices in the multiplier
    localparam int unsigned MULT_STAGES = 8;

    // multiplier bits retired by each slice
    // the extended multiplier is 2*XLEN wide, so the chain covers all of it
    localparam int unsigned MULT_CHUNK = (2 * XLEN) / MULT_STAGES;

    // destination tag carried alongside each operation
    localparam int unsigned TAG_BITS = 5;

    // multiply functions, as in the RISC-V M extension
    // mul returns the low half, the other three return the high half
    typedef enum logic [1:0] {
        // low XLEN bits of the product
        MUL_ALU_MUL    = 2'b00,
        // high half, signed x signed
        MUL_ALU_MULH   = 2'b01,
        // high half, signed x unsigned
        MUL_ALU_MULHSU = 2'b10,
        // high half, unsigned x unsigned
        MUL_ALU_MULHU  = 2'b11
    } mult_func_t;

endpackage

`default_nettype wire
